// File: tests/sd_cases.txt
# name divisor k0 k1 k2 k3 ready_mode windows exp0 exp1 exp2 exp3 exp_overrun
# ready_mode 0 always ready, 1 random ready, 2 ready held low over two windows
steady_div0 0 0 16 32 64 0 4 0 1024 2048 4096 0
steady_div3 3 64 32 16 0 0 3 4096 2048 1024 0 0
random_ready 1 16 16 64 0 1 4 1024 1024 4096 0 0
random_div7 7 32 0 64 16 1 3 2048 0 4096 1024 0
held_ready 1 0 64 16 32 2 3 0 4096 1024 2048 1
after_overrun 2 64 0 32 16 0 3 4096 0 2048 1024 0

// File: filelist.f
verilog/sd_pkg.sv
verilog/sd_clock_divider.sv
verilog/cic_decimator.sv
verilog/output_sequencer.sv
verilog/sigma_delta_processor.sv
tests/tb_clock.sv
tests/output_checker.sv
tests/sigma_delta_processor_sva.sv
tests/sigma_delta_processor_tb.sv

// File: Makefile
TOP := sigma_delta_processor_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --top-module sigma_delta_processor \
		verilog/sd_pkg.sv verilog/sd_clock_divider.sv verilog/cic_decimator.sv \
		verilog/output_sequencer.sv verilog/sigma_delta_processor.sv

sim:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	grep -q "^TEST PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log

// File: tests/sigma_delta_processor_tb.sv
// Sigma-delta front end testbench
`timescale 1ns/1ps

module sigma_delta_processor_tb import sd_pkg::*;;

    localparam int N_CHANNELS = 4;
    localparam int DECIMATION = 64;
    localparam int ORDER = 2;
    localparam int DEST_W = dest_width(N_CHANNELS);
    // Ready mode 2 releases out_ready after the third window has closed
    localparam int HOLD_RISES = 3 * DECIMATION + 4;
    localparam int QUIET_CYCLES = 200;
    localparam int SHORT_LIMIT = 100;

    logic                  clk;
    logic                  rst_n;
    logic [N_CHANNELS-1:0] data_in;
    logic                  sd_clk;
    logic                  cfg_valid;
    logic                  cfg_ready;
    logic [31:0]           cfg_data;
    logic                  out_valid;
    logic                  out_ready;
    logic [31:0]           out_data;
    logic [DEST_W-1:0]     out_dest;
    logic                  overrun;

    // Case settings shared with the input driver
    int ones [N_CHANNELS];
    int ready_mode;
    int case_id;
    int timeout_errors;
    int file_errors;

    tb_clock clock_inst (
        .clk(clk),
        .rst_n(rst_n)
    );

    sigma_delta_processor #(
        .N_CHANNELS(N_CHANNELS),
        .DECIMATION(DECIMATION),
        .ORDER(ORDER)
    ) sigma_delta_processor_inst (
        .clk(clk),
        .rst_n(rst_n),
        .data_in(data_in),
        .sd_clk(sd_clk),
        .cfg_valid(cfg_valid),
        .cfg_ready(cfg_ready),
        .cfg_data(cfg_data),
        .out_valid(out_valid),
        .out_ready(out_ready),
        .out_data(out_data),
        .out_dest(out_dest),
        .overrun(overrun)
    );

    output_checker #(
        .N_CHANNELS(N_CHANNELS),
        .SKIP_WINDOWS(ORDER),
        .DEST_W(DEST_W)
    ) output_checker_inst (
        .clk(clk),
        .rst_n(rst_n),
        .sd_clk(sd_clk),
        .out_valid(out_valid),
        .out_ready(out_ready),
        .out_data(out_data),
        .out_dest(out_dest),
        .overrun(overrun)
    );

    // Bitstreams and out_ready change on the falling edge only
    // Each channel repeats k ones followed by DECIMATION-k zeros
    initial begin : drive_inputs
        int   idx;
        int   seen_case;
        logic prev_sd_clk;
        data_in = '0;
        out_ready = 1'b1;
        idx = 0;
        seen_case = 0;
        prev_sd_clk = 1'b0;
        forever begin
            @(negedge clk);
            if (case_id != seen_case) begin
                seen_case = case_id;
                idx = 0;
            end
            // The modulator puts out its next bit after each rising sd_clk edge
            if (sd_clk && !prev_sd_clk) begin
                for (int i = 0; i < N_CHANNELS; i++) begin
                    data_in[i] = (idx % DECIMATION) < ones[i];
                end
                idx++;
            end
            prev_sd_clk = sd_clk;
            case (ready_mode)
                1: out_ready = ($urandom % 2) == 1;
                2: out_ready = idx >= HOLD_RISES;
                default: out_ready = 1'b1;
            endcase
        end
    end

    task automatic write_config(input logic enable, input logic [7:0] divisor);
        int waited;
        @(negedge clk);
        cfg_data = '0;
        cfg_data[CFG_ENABLE_BIT] = enable;
        cfg_data[CFG_DIV_MSB:CFG_DIV_LSB] = divisor;
        cfg_valid = 1'b1;
        waited = 0;
        while (!cfg_ready && waited < SHORT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!cfg_ready) begin
            timeout_errors++;
            $display("Timeout: cfg_ready never came up for a configuration write");
        end
        // With cfg_ready seen high here, the next rising edge takes the word
        @(negedge clk);
        cfg_valid = 1'b0;
    endtask

    task automatic quiet_phase();
        repeat (2) @(negedge clk);
        output_checker_inst.set_quiet(1'b1);
        repeat (QUIET_CYCLES) @(negedge clk);
        output_checker_inst.set_quiet(1'b0);
    endtask

    task automatic run_case(input string name, input int divisor, input int mode,
                            input int windows, input int exp_overrun);
        int limit;
        int waited;
        // Skipped and dropped windows are covered by the extra margin
        limit = (windows + 2 * ORDER + 4) * DECIMATION * 2 * (divisor + 1);
        output_checker_inst.start_case(name, divisor);
        case_id = case_id + 1;
        ready_mode = mode;
        write_config(1'b1, 8'(divisor));
        waited = 0;
        while (output_checker_inst.checked_windows < windows && waited < limit) begin
            @(negedge clk);
            waited++;
        end
        if (output_checker_inst.checked_windows < windows) begin
            timeout_errors++;
            $display("Timeout: case %s delivered %0d of %0d checked windows",
                     name, output_checker_inst.checked_windows, windows);
            return;
        end
        output_checker_inst.check_overrun(exp_overrun);
        output_checker_inst.stop_clock_check();
        ready_mode = 0;
        write_config(1'b0, 8'(divisor));
        // Beats still pending from the last window go out before the quiet check
        waited = 0;
        while (out_valid && waited < SHORT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (out_valid) begin
            timeout_errors++;
            $display("Timeout: case %s kept out_valid high after disable", name);
            return;
        end
        quiet_phase();
        // A second write clears any overrun left from the case
        write_config(1'b0, 8'(divisor));
        repeat (2) @(negedge clk);
        output_checker_inst.check_overrun(0);
    endtask

    initial begin : main_sequence
        int    fd;
        int    n;
        int    waited;
        int    cases_run;
        int    total;
        int    assert_errors;
        string line;
        string name;
        int    divisor;
        int    k [N_CHANNELS];
        int    mode;
        int    windows;
        int    expected [N_CHANNELS];
        int    exp_overrun;
        void'($urandom(60));
        cfg_valid = 1'b0;
        cfg_data = '0;
        ready_mode = 0;
        case_id = 0;
        timeout_errors = 0;
        file_errors = 0;
        cases_run = 0;
        for (int i = 0; i < N_CHANNELS; i++) begin
            ones[i] = 0;
        end
        waited = 0;
        while (!rst_n && waited < SHORT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!rst_n) begin
            timeout_errors++;
            $display("Timeout: reset was never released");
        end
        // Out of reset the front end is disabled
        quiet_phase();
        fd = $fopen("tests/sd_cases.txt", "r");
        if (fd == 0) begin
            file_errors++;
            $display("Could not open tests/sd_cases.txt");
        end else begin
            while (!$feof(fd) && timeout_errors == 0) begin
                line = "";
                n = $fgets(line, fd);
                if (n <= 0 || line.len() == 0 || line[0] == "#") begin
                    continue;
                end
                n = $sscanf(line, "%s %d %d %d %d %d %d %d %d %d %d %d %d", name, divisor,
                            k[0], k[1], k[2], k[3], mode, windows, expected[0],
                            expected[1], expected[2], expected[3], exp_overrun);
                if (n == 13) begin
                    for (int i = 0; i < N_CHANNELS; i++) begin
                        ones[i] = k[i];
                        output_checker_inst.set_expected(i, expected[i]);
                    end
                    run_case(name, divisor, mode, windows, exp_overrun);
                    cases_run++;
                end else if (n > 0) begin
                    file_errors++;
                    $display("Malformed line in the case file: %s", line);
                end
            end
            $fclose(fd);
        end
        if (cases_run == 0) begin
            file_errors++;
            $display("No test case was run");
        end
        assert_errors = sigma_delta_processor_inst.sequencer_inst.sequencer_sva_inst.failures;
        total = output_checker_inst.value_errors + output_checker_inst.order_errors +
                output_checker_inst.other_errors + timeout_errors + file_errors +
                assert_errors;
        $display("Cases %0d, errors: value %0d, order %0d, other %0d, timeout %0d, %s",
                 cases_run, output_checker_inst.value_errors, output_checker_inst.order_errors,
                 output_checker_inst.other_errors, timeout_errors,
                 $sformatf("file %0d, assertion %0d", file_errors, assert_errors));
        if (total == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: tests/sigma_delta_processor_sva.sv
// Output sequencer assertions
`timescale 1ns/1ps

module sigma_delta_processor_sva #(
    parameter int N_CHANNELS = 4,
    parameter int DEST_W = 2
) (
    input logic              clk,
    input logic              rst_n,
    input logic              out_valid,
    input logic              out_ready,
    input logic [31:0]       out_data,
    input logic [DEST_W-1:0] out_dest,
    input logic              overrun,
    input logic              cfg_write
);

    // Number of failed assertion attempts
    int failures = 0;

    // A stalled beat keeps valid, data and channel until it is taken
    assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_dest))
        else begin
            $error("Stalled beat changed before its transfer");
            failures++;
        end

    // Only existing channels appear on the stream
    assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> int'(out_dest) < N_CHANNELS)
        else begin
            $error("out_dest points past the last channel");
            failures++;
        end

    // The overrun flag is sticky until a configuration write
    assert property (@(posedge clk) disable iff (!rst_n)
        $fell(overrun) |-> $past(cfg_write))
        else begin
            $error("overrun cleared without a configuration write");
            failures++;
        end

endmodule

bind output_sequencer sigma_delta_processor_sva #(
    .N_CHANNELS(N_CHANNELS),
    .DEST_W(DEST_W)
) sequencer_sva_inst (
    .clk(clk),
    .rst_n(rst_n),
    .out_valid(out_valid),
    .out_ready(out_ready),
    .out_data(out_data),
    .out_dest(out_dest),
    .overrun(overrun),
    .cfg_write(cfg_write)
);

// File: tests/output_checker.sv
// Output stream checker
`timescale 1ns/1ps

module output_checker #(
    parameter int N_CHANNELS = 4,
    parameter int SKIP_WINDOWS = 2,
    parameter int DEST_W = 2
) (
    input logic              clk,
    input logic              rst_n,
    input logic              sd_clk,
    input logic              out_valid,
    input logic              out_ready,
    input logic [31:0]       out_data,
    input logic [DEST_W-1:0] out_dest,
    input logic              overrun
);

    localparam logic [DEST_W-1:0] LAST_DEST = DEST_W'(N_CHANNELS - 1);

    string             test_name = "none";
    int                exp_value [N_CHANNELS];
    int                windows_seen = 0;
    int                checked_windows = 0;
    int                value_errors = 0;
    int                order_errors = 0;
    int                other_errors = 0;
    logic              quiet = 1'b0;
    logic [DEST_W-1:0] next_dest = '0;

    // Expected sd_clk half period in clk cycles, zero while the clock is not measured
    int                half_period = 0;
    int                half_cycles = 0;
    logic              toggle_seen = 1'b0;
    logic              last_sd_clk = 1'b0;

    task automatic start_case(input string name, input int divisor);
        test_name = name;
        windows_seen = 0;
        checked_windows = 0;
        next_dest = '0;
        quiet = 1'b0;
        half_period = divisor + 1;
        toggle_seen = 1'b0;
    endtask

    // The forced low level at disable cuts a half period short
    task automatic stop_clock_check();
        half_period = 0;
        toggle_seen = 1'b0;
    endtask

    task automatic set_expected(input int ch, input int value);
        exp_value[ch] = value;
    endtask

    // While quiet is set the front end is disabled and must stay silent
    task automatic set_quiet(input logic on);
        quiet = on;
    endtask

    task automatic check_overrun(input int expected);
        if (int'(overrun) != expected) begin
            value_errors++;
            $display("CHECK FAILED test=%s overrun expected=%0d actual=%0d",
                     test_name, expected, overrun);
        end
    endtask

    // Beats are taken at the rising edge where the handshake completes
    always @(posedge clk) begin
        if (rst_n) begin
            if (quiet && sd_clk) begin
                other_errors++;
                $display("Test %s: sd_clk went high while the front end is disabled",
                         test_name);
            end
            if (quiet && out_valid) begin
                other_errors++;
                $display("Test %s: a beat was offered while the front end is disabled",
                         test_name);
            end
            // Each sd_clk level lasts divisor+1 clk cycles while the front end runs
            if (sd_clk != last_sd_clk) begin
                if (toggle_seen && half_cycles != half_period) begin
                    value_errors++;
                    $display("CHECK FAILED test=%s sd_clk half period expected=%0d actual=%0d",
                             test_name, half_period, half_cycles);
                end
                toggle_seen = (half_period != 0);
                half_cycles = 1;
            end else begin
                half_cycles++;
            end
            last_sd_clk = sd_clk;
            if (out_valid && out_ready) begin
                if (out_dest != next_dest) begin
                    order_errors++;
                    $display("CHECK FAILED test=%s out_dest expected=%0d actual=%0d",
                             test_name, next_dest, out_dest);
                end
                // Channel 0 opens a new window on the stream
                if (out_dest == '0) begin
                    windows_seen++;
                end
                // The first windows still carry the CIC start-up transient
                if (windows_seen > SKIP_WINDOWS) begin
                    if (out_data != 32'(exp_value[out_dest])) begin
                        value_errors++;
                        $display("CHECK FAILED test=%s channel %0d expected=%0d actual=%0d",
                                 test_name, out_dest, exp_value[out_dest], out_data);
                    end
                    if (out_dest == LAST_DEST) begin
                        checked_windows++;
                    end
                end
                // Resync on the beat just seen so one slip gives one error
                next_dest = (out_dest == LAST_DEST) ? '0 : out_dest + 1'b1;
            end
        end
    end

endmodule

// File: tests/tb_clock.sv
// Testbench clock and reset
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS = 20,
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk = ~clk;
        end
    end

    // Reset is held over RESET_CYCLES rising edges and released on a falling edge
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

// File: verilog/sigma_delta_processor.sv
// Multichannel sigma-delta front end
`timescale 1ns/1ps

module sigma_delta_processor import sd_pkg::*; #(
    parameter int N_CHANNELS = 4,
    parameter int DECIMATION = 64,
    parameter int ORDER = 2,
    localparam int W = cic_width(DECIMATION, ORDER),
    localparam int DEST_W = dest_width(N_CHANNELS)
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [N_CHANNELS-1:0] data_in,
    output logic                  sd_clk,
    input  logic                  cfg_valid,
    output logic                  cfg_ready,
    input  logic [31:0]           cfg_data,
    output logic                  out_valid,
    input  logic                  out_ready,
    output logic [31:0]           out_data,
    output logic [DEST_W-1:0]     out_dest,
    output logic                  overrun
);

    // Only the divisor and enable fields of the word are kept
    logic [CFG_ENABLE_BIT:0]   cfg_word;
    logic                      cfg_write;
    logic                      enable;
    logic [7:0]                divisor;
    logic                      sample_tick;
    logic                      window_tick;
    logic [N_CHANNELS*W-1:0]   results;

    // Configuration port
    // Every write is taken at once, and the overrun clear follows a cycle later
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cfg_ready <= 1'b0;
            cfg_write <= 1'b0;
            cfg_word  <= '0;
        end else begin
            cfg_ready <= 1'b1;
            cfg_write <= cfg_valid && cfg_ready;
            if (cfg_valid && cfg_ready) begin
                cfg_word <= cfg_data[CFG_ENABLE_BIT:0];
            end
        end
    end

    assign enable  = cfg_word[CFG_ENABLE_BIT];
    assign divisor = cfg_word[CFG_DIV_MSB:CFG_DIV_LSB];

    sd_clock_divider #(
        .DECIMATION(DECIMATION)
    ) clock_divider_inst (
        .clk(clk),
        .rst_n(rst_n),
        .enable(enable),
        .divisor(divisor),
        .sd_clk(sd_clk),
        .sample_tick(sample_tick),
        .window_tick(window_tick)
    );

    // One decimator per modulator, all sharing the same ticks
    for (genvar i = 0; i < N_CHANNELS; i++) begin : g_channel
        cic_decimator #(
            .DECIMATION(DECIMATION),
            .ORDER(ORDER)
        ) cic_inst (
            .clk(clk),
            .rst_n(rst_n),
            .bit_in(data_in[i]),
            .sample_tick(sample_tick),
            .window_tick(window_tick),
            .result(results[i*W +: W])
        );
    end

    output_sequencer #(
        .N_CHANNELS(N_CHANNELS),
        .DECIMATION(DECIMATION),
        .ORDER(ORDER)
    ) sequencer_inst (
        .clk(clk),
        .rst_n(rst_n),
        .enable(enable),
        .window_tick(window_tick),
        .results(results),
        .cfg_write(cfg_write),
        .out_valid(out_valid),
        .out_ready(out_ready),
        .out_data(out_data),
        .out_dest(out_dest),
        .overrun(overrun)
    );

endmodule

// File: verilog/output_sequencer.sv
// Window result sequencer
`timescale 1ns/1ps

module output_sequencer import sd_pkg::*; #(
    parameter int N_CHANNELS = 4,
    parameter int DECIMATION = 64,
    parameter int ORDER = 2,
    localparam int W = cic_width(DECIMATION, ORDER),
    localparam int DEST_W = dest_width(N_CHANNELS)
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  enable,
    input  logic                  window_tick,
    input  logic [N_CHANNELS*W-1:0] results,
    input  logic                  cfg_write,
    output logic                  out_valid,
    input  logic                  out_ready,
    output logic [31:0]           out_data,
    output logic [DEST_W-1:0]     out_dest,
    output logic                  overrun
);

    localparam logic [DEST_W-1:0] LAST_CH = DEST_W'(N_CHANNELS - 1);

    seq_state_t        state;
    logic [DEST_W-1:0] ch_idx;

    // One captured result per channel, held while the beats go out
    logic [W-1:0] hold [N_CHANNELS];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= IDLE;
            ch_idx  <= '0;
            overrun <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (enable && window_tick) begin
                        state <= WAIT_WINDOW;
                    end
                end
                // The decimators present the new results in this cycle
                WAIT_WINDOW: begin
                    state <= SEND;
                end
                SEND: begin
                    if (out_ready) begin
                        if (ch_idx == LAST_CH) begin
                            ch_idx <= '0;
                            state  <= IDLE;
                        end else begin
                            ch_idx <= ch_idx + 1'b1;
                        end
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
            // A window closing while beats are pending is lost
            // The flag stays up until software writes the configuration again,
            // and a loss in the same cycle as the write wins
            if (window_tick && state != IDLE) begin
                overrun <= 1'b1;
            end else if (cfg_write) begin
                overrun <= 1'b0;
            end
        end
    end

    // Capture all channels in one cycle, so a window is never mixed with the next
    always_ff @(posedge clk) begin
        if (state == WAIT_WINDOW) begin
            for (int i = 0; i < N_CHANNELS; i++) begin
                hold[i] <= results[i*W +: W];
            end
        end
    end

    // The beat comes straight from registers and holds until the transfer
    assign out_valid = (state == SEND);
    assign out_data  = 32'(hold[ch_idx]);
    assign out_dest  = ch_idx;

endmodule

// File: verilog/cic_decimator.sv
// CIC decimation filter for one channel
`timescale 1ns/1ps

module cic_decimator import sd_pkg::*; #(
    parameter int DECIMATION = 64,
    parameter int ORDER = 2,
    localparam int W = cic_width(DECIMATION, ORDER)
) (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         bit_in,
    input  logic         sample_tick,
    input  logic         window_tick,
    output logic [W-1:0] result
);

    // Integrator registers, stage 0 takes the raw bitstream
    logic [W-1:0] integ [ORDER];

    // Comb delay registers hold each stage input from the previous window
    logic [W-1:0] comb_dly [ORDER];

    // Combinational comb chain, stage j feeds stage j+1
    logic [W-1:0] comb_in [ORDER+1];

    // Integrators
    // Each stage adds the old value of the stage before it, which gives one
    // sample of pipeline delay per stage and keeps the adder path short
    // The sums wrap modulo 2**W, and the comb differences undo the wrap
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int j = 0; j < ORDER; j++) begin
                integ[j] <= '0;
            end
        end else if (sample_tick) begin
            integ[0] <= integ[0] + W'(bit_in);
            for (int j = 1; j < ORDER; j++) begin
                integ[j] <= integ[j] + integ[j-1];
            end
        end
    end

    // Combs
    // The chain runs at the decimated rate with a differential delay of one window
    always_comb begin
        comb_in[0] = integ[ORDER-1];
        for (int j = 0; j < ORDER; j++) begin
            comb_in[j+1] = comb_in[j] - comb_dly[j];
        end
    end

    // Window end
    // The delays take this window's stage inputs and the output register
    // takes the last difference, so result is valid one cycle after window_tick
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int j = 0; j < ORDER; j++) begin
                comb_dly[j] <= '0;
            end
            result <= '0;
        end else if (window_tick) begin
            for (int j = 0; j < ORDER; j++) begin
                comb_dly[j] <= comb_in[j];
            end
            result <= comb_in[ORDER];
        end
    end

    // A periodic input with k ones per window settles at k * DECIMATION**(ORDER-1)
    // once ORDER full windows have passed through the chain
    // That value fits W bits even for a stream of all ones

endmodule

// File: verilog/sd_clock_divider.sv
// Modulator clock divider
`timescale 1ns/1ps

module sd_clock_divider #(
    parameter int DECIMATION = 64
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       enable,
    input  logic [7:0] divisor,
    output logic       sd_clk,
    output logic       sample_tick,
    output logic       window_tick
);

    localparam int SAMPLE_W = (DECIMATION > 1) ? $clog2(DECIMATION) : 1;
    localparam logic [SAMPLE_W-1:0] LAST_SAMPLE = SAMPLE_W'(DECIMATION - 1);

    logic [7:0]          half_cnt;
    logic [SAMPLE_W-1:0] sample_cnt;
    logic                half_done;
    logic                rising;

    // A greater-or-equal compare keeps the counter from running
    // through 255 when the divisor shrinks in the middle of a half period
    assign half_done = (half_cnt >= divisor);

    // sd_clk goes high at the edge that closes a low half period
    assign rising = half_done && !sd_clk;

    always_ff @(posedge clk) begin
        if (!rst_n || !enable) begin
            // Both counters restart so the first window lines up with enable
            half_cnt    <= '0;
            sample_cnt  <= '0;
            sd_clk      <= 1'b0;
            sample_tick <= 1'b0;
            window_tick <= 1'b0;
        end else begin
            if (half_done) begin
                half_cnt <= '0;
                sd_clk   <= ~sd_clk;
            end else begin
                half_cnt <= half_cnt + 8'd1;
            end
            // Registered together with sd_clk, so the tick shares its first high cycle
            sample_tick <= rising;
            window_tick <= rising && (sample_cnt == LAST_SAMPLE);
            if (rising) begin
                if (sample_cnt == LAST_SAMPLE) begin
                    sample_cnt <= '0;
                end else begin
                    sample_cnt <= sample_cnt + 1'b1;
                end
            end
        end
    end

endmodule

// File: verilog/sd_pkg.sv
// Sigma-delta front end definitions
package sd_pkg;

    // Output sequencer states
    // IDLE waits for the end of a window, WAIT_WINDOW lets the CIC results settle
    // for one cycle and captures them, SEND walks the channels over the stream
    typedef enum logic [1:0] {
        IDLE,
        SEND,
        WAIT_WINDOW
    } seq_state_t;

    // Field positions inside the 32-bit configuration word
    localparam int CFG_DIV_LSB = 0;
    localparam int CFG_DIV_MSB = 7;
    localparam int CFG_ENABLE_BIT = 8;

    // Register growth of a CIC filter fed with unsigned one-bit samples
    // The full-scale result is DECIMATION**ORDER, which needs one bit more
    // than ORDER times log2 of the ratio
    function automatic int cic_width(input int decimation, input int order);
        return order * $clog2(decimation) + 1;
    endfunction

    // Width of a channel index, never less than one bit
    function automatic int dest_width(input int n_channels);
        int w;
        w = $clog2(n_channels);
        if (w < 1) begin
            w = 1;
        end
        return w;
    endfunction

endpackage
